// ==== logic/id_defs.svh ====
/*
 * Decode stage widths and constants
 * Shared by all RTL blocks of the decode stage
 */
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// Datapath and register file geometry
`define ID_XLEN        32
`define ID_REG_AW      5
`define ID_NUM_REGS    32

// Custom unit operation field
`define ID_CUSTOM_OP_W 5
`define ID_PC_INCR     4

`endif

// ==== logic/id_pkg.sv ====
/*
 * Decode stage package
 * Opcode, ALU operation, mux select and FSM state encodings
 */
`include "id_defs.svh"

package id_pkg;

  typedef enum logic [6:0] {
    OPC_OP      = 7'h33,
    OPC_OP_IMM  = 7'h13,
    OPC_LUI     = 7'h37,
    OPC_AUIPC   = 7'h17,
    OPC_LOAD    = 7'h03,
    OPC_STORE   = 7'h23,
    OPC_BRANCH  = 7'h63,
    OPC_CUSTOM0 = 7'h0b
  } opcode_e;

  typedef enum logic [4:0] {
    // Arithmetic and logic
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // Branch comparisons
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic [2:0] {IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_INCR_PC} imm_b_sel_e;
  typedef enum logic {RF_WD_EX, RF_WD_LSU} rf_wd_sel_e;
  typedef enum logic {IDLE, WAIT_MULTICYCLE} id_fsm_e;

endpackage

// ==== logic/id_ctrl_if.sv ====
/*
 * Decoded control bundle
 * Carries decoder outputs to register file, operand mux and FSM
 */
`timescale 1ns/10ps
`include "id_defs.svh"

interface id_ctrl_if;
  logic [`ID_REG_AW-1:0]      raddr_a;
  logic [`ID_REG_AW-1:0]      raddr_b;
  logic [`ID_REG_AW-1:0]      waddr;
  id_pkg::alu_op_e            alu_operator;
  id_pkg::op_a_sel_e          op_a_sel;
  id_pkg::op_b_sel_e          op_b_sel;
  id_pkg::imm_b_sel_e         imm_b_sel;
  logic                       rf_we_dec;
  id_pkg::rf_wd_sel_e         rf_wdata_sel;
  logic                       data_req_dec;
  logic                       data_we;
  logic                       custom_en_dec;
  logic [`ID_CUSTOM_OP_W-1:0] custom_op;
  logic                       branch_in_dec;
  logic                       illegal;

  modport decoder (output raddr_a, raddr_b, waddr, alu_operator, op_a_sel, op_b_sel,
                   imm_b_sel, rf_we_dec, rf_wdata_sel, data_req_dec, data_we,
                   custom_en_dec, custom_op, branch_in_dec, illegal);
  modport regfile (input raddr_a, raddr_b, waddr);
  modport operand (input op_a_sel, op_b_sel, imm_b_sel, rf_wdata_sel);
  modport fsm (input data_req_dec, custom_en_dec, rf_we_dec, branch_in_dec);
endinterface

// ==== logic/id_decoder.sv ====
/*
 * Instruction decoder
 * Maps an RV32I subset plus custom-0 onto control fields,
 * anything not listed is flagged illegal
 */
`timescale 1ns/10ps
`include "id_defs.svh"

module id_decoder import id_pkg::*; (
  input  logic [`ID_XLEN-1:0] instr_i,
  id_ctrl_if.decoder          ctrl
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       rf_we;
  logic       data_req;
  logic       data_we;
  logic       custom_en;
  logic       branch_in;
  logic       illegal_insn;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register fields sit at the same place in every format
  assign ctrl.raddr_a   = instr_i[19:15];
  assign ctrl.raddr_b   = instr_i[24:20];
  assign ctrl.waddr     = instr_i[11:7];
  // Custom op lives in the upper funct7 bits
  assign ctrl.custom_op = instr_i[31 -: `ID_CUSTOM_OP_W];

  always_comb begin
    ctrl.alu_operator = ALU_ADD;
    ctrl.op_a_sel     = OP_A_REG_A;
    ctrl.op_b_sel     = OP_B_IMM;
    ctrl.imm_b_sel    = IMM_B_I;
    ctrl.rf_wdata_sel = RF_WD_EX;
    rf_we             = 1'b0;
    data_req          = 1'b0;
    data_we           = 1'b0;
    custom_en         = 1'b0;
    branch_in         = 1'b0;
    illegal_insn      = 1'b0;

    case (instr_i[6:0])
      OPC_OP: begin
        ctrl.op_b_sel = OP_B_REG_B;
        rf_we         = 1'b1;
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  ctrl.alu_operator = ALU_ADD;
            3'b001:  ctrl.alu_operator = ALU_SLL;
            3'b010:  ctrl.alu_operator = ALU_SLT;
            3'b011:  ctrl.alu_operator = ALU_SLTU;
            3'b100:  ctrl.alu_operator = ALU_XOR;
            3'b101:  ctrl.alu_operator = ALU_SRL;
            3'b110:  ctrl.alu_operator = ALU_OR;
            default: ctrl.alu_operator = ALU_AND;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          ctrl.alu_operator = ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          ctrl.alu_operator = ALU_SRA;
        end else begin
          illegal_insn = 1'b1;
        end
      end

      OPC_OP_IMM: begin
        rf_we = 1'b1;
        case (funct3)
          3'b000: ctrl.alu_operator = ALU_ADD;
          3'b010: ctrl.alu_operator = ALU_SLT;
          3'b011: ctrl.alu_operator = ALU_SLTU;
          3'b100: ctrl.alu_operator = ALU_XOR;
          3'b110: ctrl.alu_operator = ALU_OR;
          3'b111: ctrl.alu_operator = ALU_AND;
          3'b001: begin
            ctrl.alu_operator = ALU_SLL;
            illegal_insn      = (funct7 != 7'b0000000);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            ctrl.alu_operator = (funct7 == 7'b0100000) ? ALU_SRA : ALU_SRL;
            illegal_insn      = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end

      OPC_LUI, OPC_AUIPC: begin
        ctrl.op_a_sel  = (instr_i[6:0] == OPC_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        ctrl.imm_b_sel = IMM_B_U;
        rf_we          = 1'b1;
      end

      OPC_LOAD: begin
        // Word loads only
        ctrl.rf_wdata_sel = RF_WD_LSU;
        rf_we             = 1'b1;
        data_req          = 1'b1;
        illegal_insn      = (funct3 != 3'b010);
      end

      OPC_STORE: begin
        ctrl.imm_b_sel = IMM_B_S;
        data_req       = 1'b1;
        data_we        = 1'b1;
        illegal_insn   = (funct3 != 3'b010);
      end

      OPC_BRANCH: begin
        ctrl.op_b_sel  = OP_B_REG_B;
        ctrl.imm_b_sel = IMM_B_B;
        branch_in      = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_operator = ALU_EQ;
          3'b001:  ctrl.alu_operator = ALU_NE;
          3'b100:  ctrl.alu_operator = ALU_LT;
          3'b101:  ctrl.alu_operator = ALU_GE;
          3'b110:  ctrl.alu_operator = ALU_LTU;
          3'b111:  ctrl.alu_operator = ALU_GEU;
          default: illegal_insn      = 1'b1;
        endcase
      end

      OPC_CUSTOM0: begin
        ctrl.op_b_sel = OP_B_REG_B;
        rf_we         = 1'b1;
        custom_en     = 1'b1;
      end

      default: illegal_insn = 1'b1;
    endcase
  end

  // An illegal encoding must not request anything or touch the register file
  assign ctrl.rf_we_dec     = rf_we & ~illegal_insn;
  assign ctrl.data_req_dec  = data_req & ~illegal_insn;
  assign ctrl.data_we       = data_we & ~illegal_insn;
  assign ctrl.custom_en_dec = custom_en & ~illegal_insn;
  assign ctrl.branch_in_dec = branch_in & ~illegal_insn;
  assign ctrl.illegal       = illegal_insn;

endmodule

// ==== logic/id_register_file.sv ====
/*
 * Register file, two read ports and one write port
 * x0 is hardwired to zero
 */
`timescale 1ns/10ps
`include "id_defs.svh"

module id_register_file import id_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  id_ctrl_if.regfile         ctrl,
  input  logic               we_i,
  input  logic [`ID_XLEN-1:0] wdata_i,
  output logic [`ID_XLEN-1:0] rdata_a_o,
  output logic [`ID_XLEN-1:0] rdata_b_o
);

  logic [`ID_XLEN-1:0] rf_q [`ID_NUM_REGS];

  // Entry 0 is cleared at reset and never written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `ID_NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (we_i && ctrl.waddr != '0) begin
      rf_q[ctrl.waddr] <= wdata_i;
    end
  end

  assign rdata_a_o = (ctrl.raddr_a == '0) ? '0 : rf_q[ctrl.raddr_a];
  assign rdata_b_o = (ctrl.raddr_b == '0) ? '0 : rf_q[ctrl.raddr_b];

endmodule

// ==== logic/id_operand_mux.sv ====
/*
 * Immediate extraction and operand selection
 * Also picks the register write-back source
 */
`timescale 1ns/10ps
`include "id_defs.svh"

module id_operand_mux import id_pkg::*; (
  id_ctrl_if.operand          ctrl,
  input  logic [`ID_XLEN-1:0] instr_i,
  input  logic [`ID_XLEN-1:0] pc_i,
  input  logic [`ID_XLEN-1:0] rdata_a_i,
  input  logic [`ID_XLEN-1:0] rdata_b_i,
  input  logic [`ID_XLEN-1:0] wdata_ex_i,
  input  logic [`ID_XLEN-1:0] wdata_lsu_i,
  input  logic                branch_set_i,
  output logic [`ID_XLEN-1:0] operand_a_o,
  output logic [`ID_XLEN-1:0] operand_b_o,
  output logic [`ID_XLEN-1:0] rf_wdata_o
);

  logic [`ID_XLEN-1:0] imm_i_type;
  logic [`ID_XLEN-1:0] imm_s_type;
  logic [`ID_XLEN-1:0] imm_b_type;
  logic [`ID_XLEN-1:0] imm_u_type;
  logic [`ID_XLEN-1:0] imm_b;
  op_a_sel_e           op_a_sel;
  op_b_sel_e           op_b_sel;
  imm_b_sel_e          imm_b_sel;

  ////////////////////
  // Immediates
  ////////////////////

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  // Second cycle of a taken branch computes the target PC + imm
  assign op_a_sel  = branch_set_i ? OP_A_CURRPC : ctrl.op_a_sel;
  assign op_b_sel  = branch_set_i ? OP_B_IMM    : ctrl.op_b_sel;
  assign imm_b_sel = branch_set_i ? IMM_B_B     : ctrl.imm_b_sel;

  ////////////////////
  // Operand muxes
  ////////////////////

  always_comb begin
    case (op_a_sel)
      OP_A_REG_A:  operand_a_o = rdata_a_i;
      OP_A_CURRPC: operand_a_o = pc_i;
      default:     operand_a_o = '0;
    endcase
  end

  always_comb begin
    case (imm_b_sel)
      IMM_B_I:       imm_b = imm_i_type;
      IMM_B_S:       imm_b = imm_s_type;
      IMM_B_B:       imm_b = imm_b_type;
      IMM_B_U:       imm_b = imm_u_type;
      IMM_B_INCR_PC: imm_b = `ID_XLEN'(`ID_PC_INCR);
      default:       imm_b = imm_i_type;
    endcase
  end

  assign operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rdata_b_i;

  // Write-back source
  assign rf_wdata_o = (ctrl.rf_wdata_sel == RF_WD_LSU) ? wdata_lsu_i : wdata_ex_i;

endmodule

// ==== logic/id_multicycle_fsm.sv ====
/*
 * ID-EX/WB multicycle FSM
 * Stalls loads, stores, custom ops and taken branches, gates
 * requests and write-back, and produces the retire pulse
 */
`timescale 1ns/10ps
`include "id_defs.svh"

module id_multicycle_fsm import id_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  id_ctrl_if.fsm ctrl,
  input  logic   instr_new_i,
  input  logic   lsu_valid_i,
  input  logic   ex_valid_i,
  input  logic   branch_decision_i,
  output logic   rf_we_o,
  output logic   data_req_o,
  output logic   custom_en_o,
  output logic   stall_o,
  output logic   branch_set_o,
  output logic   instr_ret_o
);

  id_fsm_e state_q, state_d;
  logic    done_q, done_d;
  logic    branch_set_q, branch_set_d;
  logic    instr_multicycle;
  logic    instr_executing;
  logic    multicycle_end;
  logic    rf_we_wb;

  assign instr_multicycle = ctrl.data_req_dec | ctrl.custom_en_dec | ctrl.branch_in_dec;
  // Executing while new, or while a multicycle op is still pending
  assign instr_executing  = instr_new_i | (instr_multicycle & ~done_q);
  assign data_req_o       = instr_executing & ctrl.data_req_dec;
  assign custom_en_o      = instr_executing & ctrl.custom_en_dec;

  // Taken branch always finishes in its second cycle
  assign multicycle_end = (ctrl.data_req_dec & lsu_valid_i) |
                          (ctrl.custom_en_dec & ex_valid_i) | ctrl.branch_in_dec;

  // LSU and custom results land at completion, others at issue
  assign rf_we_o = (ctrl.data_req_dec | ctrl.custom_en_dec) ? rf_we_wb :
                   (instr_new_i & ctrl.rf_we_dec);
  assign branch_set_o = branch_set_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      done_q       <= 1'b1;  // Nothing in flight out of reset
      branch_set_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      done_q       <= done_d;
      branch_set_q <= branch_set_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    done_d       = done_q;
    branch_set_d = 1'b0;
    rf_we_wb     = 1'b0;
    stall_o      = 1'b0;
    instr_ret_o  = 1'b0;

    case (state_q)
      IDLE: begin
        if (instr_new_i) begin
          if (ctrl.data_req_dec | ctrl.custom_en_dec) begin
            state_d = WAIT_MULTICYCLE;
            done_d  = 1'b0;
            stall_o = 1'b1;
          end else if (ctrl.branch_in_dec & branch_decision_i) begin
            state_d      = WAIT_MULTICYCLE;
            done_d       = 1'b0;
            stall_o      = 1'b1;
            branch_set_d = 1'b1;
          end else begin
            done_d      = 1'b1;
            instr_ret_o = 1'b1;
          end
        end
      end

      default: begin
        if (multicycle_end) begin
          state_d     = IDLE;
          done_d      = 1'b1;
          rf_we_wb    = ctrl.rf_we_dec;
          instr_ret_o = 1'b1;
        end else begin
          stall_o = 1'b1;
        end
      end
    endcase
  end

endmodule

// ==== logic/id_stage.sv ====
/*
 * Instruction decode stage top level
 * Decoder, register file, operand muxes and multicycle FSM
 */
`timescale 1ns/10ps
`include "id_defs.svh"

module id_stage import id_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       instr_new_i,
  input  logic                       lsu_valid_i,
  input  logic                       ex_valid_i,
  input  logic                       branch_decision_i,
  input  logic [`ID_XLEN-1:0]        instr_rdata_i,
  input  logic [`ID_XLEN-1:0]        pc_id_i,
  input  logic [`ID_XLEN-1:0]        regfile_wdata_ex_i,
  input  logic [`ID_XLEN-1:0]        regfile_wdata_lsu_i,
  output logic                       illegal_insn_o,
  output logic                       stall_o,
  output logic                       instr_ret_o,
  output logic                       branch_set_o,
  output alu_op_e                    alu_operator_o,
  output logic [`ID_XLEN-1:0]        alu_operand_a_o,
  output logic [`ID_XLEN-1:0]        alu_operand_b_o,
  output logic                       data_req_o,
  output logic                       data_we_o,
  output logic [`ID_XLEN-1:0]        data_wdata_o,
  output logic [`ID_XLEN-1:0]        custom_rs1_o,
  output logic [`ID_XLEN-1:0]        custom_rs2_o,
  output logic                       custom_en_o,
  output logic [`ID_CUSTOM_OP_W-1:0] custom_op_o
);

  logic [`ID_XLEN-1:0] rdata_a;
  logic [`ID_XLEN-1:0] rdata_b;
  logic [`ID_XLEN-1:0] rf_wdata;
  logic                rf_we;

  id_ctrl_if ctrl_if ();

  id_decoder u_decoder (
    .instr_i (instr_rdata_i),
    .ctrl    (ctrl_if)
  );

  id_register_file u_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .ctrl      (ctrl_if),
    .we_i      (rf_we),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  id_operand_mux u_operand_mux (
    .ctrl         (ctrl_if),
    .instr_i      (instr_rdata_i),
    .pc_i         (pc_id_i),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .wdata_ex_i   (regfile_wdata_ex_i),
    .wdata_lsu_i  (regfile_wdata_lsu_i),
    .branch_set_i (branch_set_o),
    .operand_a_o  (alu_operand_a_o),
    .operand_b_o  (alu_operand_b_o),
    .rf_wdata_o   (rf_wdata)
  );

  id_multicycle_fsm u_multicycle_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ctrl              (ctrl_if),
    .instr_new_i       (instr_new_i),
    .lsu_valid_i       (lsu_valid_i),
    .ex_valid_i        (ex_valid_i),
    .branch_decision_i (branch_decision_i),
    .rf_we_o           (rf_we),
    .data_req_o        (data_req_o),
    .custom_en_o       (custom_en_o),
    .stall_o           (stall_o),
    .branch_set_o      (branch_set_o),
    .instr_ret_o       (instr_ret_o)
  );

  // Illegal is only reported for a freshly issued instruction
  assign illegal_insn_o = instr_new_i & ctrl_if.illegal;
  assign alu_operator_o = ctrl_if.alu_operator;
  assign data_we_o      = ctrl_if.data_we;
  assign custom_op_o    = ctrl_if.custom_op;
  assign data_wdata_o   = rdata_b;
  assign custom_rs1_o   = rdata_a;
  assign custom_rs2_o   = rdata_b;

endmodule

// ==== tests/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source
 * 20 ns clock, reset held low for the first two cycles
 */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #10 clk_o = ~clk_o;

endmodule

// ==== tests/id_stage_assertions.sv ====
/*
 * Decode stage protocol checks
 * Bound onto the top level by the testbench
 */
`timescale 1ns/10ps

module id_stage_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_new_i,
  input logic stall_o,
  input logic data_req_o,
  input logic custom_en_o,
  input logic branch_set_o
);

  // Failed checks so far, polled by the testbench
  int unsigned fail_count = 0;

  // A stalled cycle is never followed by a new instruction
  new_after_stall_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) stall_o |=> !instr_new_i
  ) else begin
    fail_count++;
    $error("instr_new_i arrived while the stage was stalled");
  end

  // LSU and custom unit never requested together
  req_exclusive_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(data_req_o && custom_en_o)
  ) else begin
    fail_count++;
    $error("data_req_o and custom_en_o are both high");
  end

  // Second cycle of a taken branch releases the stall
  branch_set_release_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) branch_set_o |-> !stall_o
  ) else begin
    fail_count++;
    $error("stall_o high together with branch_set_o");
  end

endmodule

// ==== tests/id_stage_tb.sv ====
/*
 * Decode stage testbench
 * Random RV32I subset stream checked against a register and PC model
 */
`timescale 1ns/10ps
`include "id_defs.svh"

module id_stage_tb import id_pkg::*; ();

  localparam int NUM_INSTR     = 300;
  localparam int STALL_TIMEOUT = 20;
  localparam int RESET_TIMEOUT = 10;

  logic                       clk;
  logic                       rst_n;
  logic                       instr_new;
  logic                       lsu_valid;
  logic                       ex_valid;
  logic                       branch_decision;
  logic [`ID_XLEN-1:0]        instr_rdata;
  logic [`ID_XLEN-1:0]        pc_id;
  logic [`ID_XLEN-1:0]        wdata_ex;
  logic [`ID_XLEN-1:0]        wdata_lsu;
  logic                       illegal_insn;
  logic                       stall;
  logic                       instr_ret;
  logic                       branch_set;
  alu_op_e                    alu_operator;
  logic [`ID_XLEN-1:0]        operand_a;
  logic [`ID_XLEN-1:0]        operand_b;
  logic                       data_req;
  logic                       data_we;
  logic [`ID_XLEN-1:0]        data_wdata;
  logic [`ID_XLEN-1:0]        custom_rs1;
  logic [`ID_XLEN-1:0]        custom_rs2;
  logic                       custom_en;
  logic [`ID_CUSTOM_OP_W-1:0] custom_op;

  // Reference model state
  logic [`ID_XLEN-1:0] model_rf [`ID_NUM_REGS];
  logic [`ID_XLEN-1:0] model_pc;
  logic [31:0]         lfsr_q;
  int                  error_count;

  // RV32I funct3 to ALU operation
  alu_op_e    arith_ops [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
  alu_op_e    branch_ops [8] = '{ALU_EQ, ALU_NE, ALU_EQ, ALU_EQ,
                                 ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  logic [2:0] branch_f3 [8] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd5};

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  id_stage u_dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .instr_new_i         (instr_new),
    .lsu_valid_i         (lsu_valid),
    .ex_valid_i          (ex_valid),
    .branch_decision_i   (branch_decision),
    .instr_rdata_i       (instr_rdata),
    .pc_id_i             (pc_id),
    .regfile_wdata_ex_i  (wdata_ex),
    .regfile_wdata_lsu_i (wdata_lsu),
    .illegal_insn_o      (illegal_insn),
    .stall_o             (stall),
    .instr_ret_o         (instr_ret),
    .branch_set_o        (branch_set),
    .alu_operator_o      (alu_operator),
    .alu_operand_a_o     (operand_a),
    .alu_operand_b_o     (operand_b),
    .data_req_o          (data_req),
    .data_we_o           (data_we),
    .data_wdata_o        (data_wdata),
    .custom_rs1_o        (custom_rs1),
    .custom_rs2_o        (custom_rs2),
    .custom_en_o         (custom_en),
    .custom_op_o         (custom_op)
  );

  bind id_stage id_stage_assertions u_assertions (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .instr_new_i  (instr_new_i),
    .stall_o      (stall_o),
    .data_req_o   (data_req_o),
    .custom_en_o  (custom_en_o),
    .branch_set_o (branch_set_o)
  );

  ////////////////////
  // Random source
  ////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic is_listed(input logic [6:0] opc);
    return opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI || opc == OPC_AUIPC ||
           opc == OPC_LOAD || opc == OPC_STORE || opc == OPC_BRANCH || opc == OPC_CUSTOM0;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_alu_op(input alu_op_e actual, input alu_op_e expected,
                              input string what);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %0t: %s is %s, expected %s", $time, what,
                          actual.name(), expected.name()));
    end
  endtask

  task automatic check_word(input logic [`ID_XLEN-1:0] actual,
                            input logic [`ID_XLEN-1:0] expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what,
                          actual, expected));
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what,
                          actual, expected));
    end
  endtask

  task automatic check_retired_now();
    check_bit(illegal_insn, 1'b0, "illegal_insn_o");
    check_bit(stall, 1'b0, "stall_o");
    check_bit(instr_ret, 1'b1, "instr_ret_o");
    check_bit(data_req, 1'b0, "data_req_o");
    check_bit(custom_en, 1'b0, "custom_en_o");
  endtask

  task automatic check_multicycle_start();
    check_bit(illegal_insn, 1'b0, "illegal_insn_o");
    check_bit(stall, 1'b1, "stall_o in first cycle");
    check_bit(instr_ret, 1'b0, "instr_ret_o in first cycle");
  endtask

  task automatic model_write(input logic [4:0] rd, input logic [`ID_XLEN-1:0] value);
    // x0 keeps its zero
    if (rd != 5'd0) begin
      model_rf[rd] = value;
    end
  endtask

  // Bound protocol checks end the run at their first failure
  always @(posedge clk) begin
    if (u_dut.u_assertions.fail_count != 0) begin
      abort_run("A protocol assertion in the bound checker failed");
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic issue(input logic [31:0] instr);
    logic [31:0] ex_val;
    logic [31:0] lsu_val;
    logic        taken;
    ex_val  = rand_bits(32);
    lsu_val = rand_bits(32);
    taken   = 1'(rand_bits(1));
    @(posedge clk);
    instr_new       <= 1'b1;
    instr_rdata     <= instr;
    pc_id           <= model_pc;
    wdata_ex        <= ex_val;
    wdata_lsu       <= lsu_val;
    branch_decision <= taken;
    lsu_valid       <= 1'b0;
    ex_valid        <= 1'b0;
    @(negedge clk);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    instr_new <= 1'b0;
    lsu_valid <= 1'b0;
    ex_valid  <= 1'b0;
    @(negedge clk);
  endtask

  // Pulses the completion strobe after delay cycles, then waits for stall_o to drop
  task automatic wait_stall_release(input logic lsu_done, input logic ex_done,
                                    input int delay, output int cycles);
    cycles = 0;
    while (stall) begin
      @(posedge clk);
      instr_new <= 1'b0;
      lsu_valid <= lsu_done && (cycles == delay);
      ex_valid  <= ex_done && (cycles == delay);
      @(negedge clk);
      cycles++;
      if (cycles > STALL_TIMEOUT) begin
        abort_run("Timeout: stall_o did not fall within 20 cycles");
      end
      if (lsu_done) begin
        check_bit(data_req, 1'b1, "data_req_o while waiting");
      end
      if (ex_done) begin
        check_bit(custom_en, 1'b1, "custom_en_o while waiting");
      end
    end
  endtask

  task automatic run_one();
    logic [2:0]          cls;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [2:0]          f3;
    logic [6:0]          f7;
    logic [6:0]          opc;
    logic [11:0]         imm12;
    logic [19:0]         imm20;
    logic [12:0]         imm13;
    logic                alt;
    logic [31:0]         instr;
    logic [`ID_XLEN-1:0] exp_imm;
    logic [`ID_XLEN-1:0] pc_step;
    alu_op_e             exp_op;
    int                  delay;
    int                  cycles;

    cls     = 3'(rand_bits(3));
    rd      = 5'(rand_bits(5));
    rs1     = 5'(rand_bits(5));
    rs2     = 5'(rand_bits(5));
    f3      = 3'(rand_bits(3));
    f7      = 7'(rand_bits(7));
    imm12   = 12'(rand_bits(12));
    alt     = 1'(rand_bits(1));
    delay   = int'(rand_bits(3)) % 5;
    pc_step = `ID_XLEN'(`ID_PC_INCR);
    exp_imm = {{20{imm12[11]}}, imm12};

    case (cls)
      3'd0: begin
        // Register-register ALU
        f7     = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        exp_op = arith_ops[f3];
        if (f7 == 7'h20) begin
          exp_op = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
        end
        issue({f7, rs2, rs1, f3, rd, OPC_OP});
        check_alu_op(alu_operator, exp_op, "alu_operator_o");
        check_word(operand_a, model_rf[rs1], "operand A");
        check_word(operand_b, model_rf[rs2], "operand B");
        check_retired_now();
        model_write(rd, wdata_ex);
      end
      3'd1: begin
        // Shift amounts keep the upper funct7 bits legal
        if (f3 == 3'd1) begin
          imm12[11:5] = 7'h00;
        end
        if (f3 == 3'd5) begin
          imm12[11:5] = alt ? 7'h20 : 7'h00;
        end
        exp_op  = (f3 == 3'd5 && alt) ? ALU_SRA : arith_ops[f3];
        exp_imm = {{20{imm12[11]}}, imm12};
        issue({imm12, rs1, f3, rd, OPC_OP_IMM});
        check_alu_op(alu_operator, exp_op, "alu_operator_o");
        check_word(operand_a, model_rf[rs1], "operand A");
        check_word(operand_b, exp_imm, "operand B");
        check_retired_now();
        model_write(rd, wdata_ex);
      end
      3'd2: begin
        imm20 = 20'(rand_bits(20));
        opc   = alt ? OPC_LUI : OPC_AUIPC;
        issue({imm20, rd, opc});
        check_word(operand_a, alt ? '0 : model_pc, "operand A");
        check_word(operand_b, {imm20, 12'h000}, "operand B");
        check_retired_now();
        model_write(rd, wdata_ex);
      end
      3'd3: begin
        issue({imm12, rs1, 3'b010, rd, OPC_LOAD});
        check_bit(data_req, 1'b1, "data_req_o");
        check_bit(data_we, 1'b0, "data_we_o");
        check_bit(custom_en, 1'b0, "custom_en_o");
        check_word(operand_a, model_rf[rs1], "operand A");
        check_word(operand_b, exp_imm, "operand B");
        check_multicycle_start();
        wait_stall_release(1'b1, 1'b0, delay, cycles);
        check_word(32'(cycles), 32'(delay + 1), "stall cycles of load");
        check_bit(instr_ret, 1'b1, "instr_ret_o at load completion");
        model_write(rd, wdata_lsu);
      end
      3'd4: begin
        issue({imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], OPC_STORE});
        check_bit(data_req, 1'b1, "data_req_o");
        check_bit(data_we, 1'b1, "data_we_o");
        check_bit(custom_en, 1'b0, "custom_en_o");
        check_word(data_wdata, model_rf[rs2], "data_wdata_o");
        check_word(operand_a, model_rf[rs1], "operand A");
        check_word(operand_b, exp_imm, "operand B");
        check_multicycle_start();
        wait_stall_release(1'b1, 1'b0, delay, cycles);
        check_word(32'(cycles), 32'(delay + 1), "stall cycles of store");
        check_bit(instr_ret, 1'b1, "instr_ret_o at store completion");
      end
      3'd5: begin
        f3      = branch_f3[f3];
        imm13   = {imm12, 1'b0};
        exp_imm = {{19{imm13[12]}}, imm13};
        issue({imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], OPC_BRANCH});
        check_bit(illegal_insn, 1'b0, "illegal_insn_o");
        check_alu_op(alu_operator, branch_ops[f3], "alu_operator_o");
        check_word(operand_a, model_rf[rs1], "operand A");
        check_word(operand_b, model_rf[rs2], "operand B");
        check_bit(branch_set, 1'b0, "branch_set_o in first cycle");
        check_bit(data_req, 1'b0, "data_req_o");
        check_bit(custom_en, 1'b0, "custom_en_o");
        if (branch_decision) begin
          check_bit(stall, 1'b1, "stall_o of taken branch");
          check_bit(instr_ret, 1'b0, "instr_ret_o of taken branch");
          wait_stall_release(1'b0, 1'b0, 0, cycles);
          check_word(32'(cycles), 32'd1, "extra cycles of taken branch");
          check_bit(branch_set, 1'b1, "branch_set_o in second cycle");
          check_word(operand_a, model_pc, "branch target operand A");
          check_word(operand_b, exp_imm, "branch target operand B");
          check_bit(instr_ret, 1'b1, "instr_ret_o in second cycle");
          pc_step = exp_imm;
        end else begin
          check_retired_now();
        end
      end
      3'd6: begin
        issue({f7, rs2, rs1, f3, rd, OPC_CUSTOM0});
        check_bit(custom_en, 1'b1, "custom_en_o");
        check_bit(data_req, 1'b0, "data_req_o");
        check_word(32'(custom_op), 32'(f7[6:2]), "custom_op_o");
        check_word(custom_rs1, model_rf[rs1], "custom_rs1_o");
        check_word(custom_rs2, model_rf[rs2], "custom_rs2_o");
        check_multicycle_start();
        wait_stall_release(1'b0, 1'b1, delay, cycles);
        check_word(32'(cycles), 32'(delay + 1), "stall cycles of custom op");
        check_bit(instr_ret, 1'b1, "instr_ret_o at custom completion");
        model_write(rd, wdata_ex);
      end
      default: begin
        // Unlisted major opcode with random upper bits
        do begin
          opc = 7'(rand_bits(7));
        end while (is_listed(opc));
        instr = {25'(rand_bits(25)), opc};
        issue(instr);
        check_bit(illegal_insn, 1'b1, "illegal_insn_o");
        check_bit(data_req, 1'b0, "data_req_o on illegal");
        check_bit(custom_en, 1'b0, "custom_en_o on illegal");
        check_bit(stall, 1'b0, "stall_o on illegal");
      end
    endcase

    model_pc = model_pc + pc_step;
  endtask

  initial begin
    int reset_cycles;

    instr_new       = 1'b0;
    lsu_valid       = 1'b0;
    ex_valid        = 1'b0;
    branch_decision = 1'b0;
    instr_rdata     = '0;
    pc_id           = '0;
    wdata_ex        = '0;
    wdata_lsu       = '0;
    lfsr_q          = 32'hf9167041;
    error_count     = 0;
    model_pc        = 32'h0000_1000;
    for (int i = 0; i < `ID_NUM_REGS; i++) begin
      model_rf[i] = '0;
    end

    reset_cycles = 0;
    while (!rst_n) begin
      @(posedge clk);
      reset_cycles++;
      if (reset_cycles > RESET_TIMEOUT) begin
        abort_run("Reset was never released");
      end
    end

    for (int n = 0; n < NUM_INSTR; n++) begin
      run_one();
      // Occasional bubble between instructions
      if (rand_bits(2) == 32'd0) begin
        idle_cycle();
      end
    end
    idle_cycle();

    if (error_count == 0 && u_dut.u_assertions.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+logic
logic/id_pkg.sv
logic/id_ctrl_if.sv
logic/id_decoder.sv
logic/id_register_file.sv
logic/id_operand_mux.sv
logic/id_multicycle_fsm.sv
logic/id_stage.sv
tests/tb_clock_gen.sv
tests/id_stage_assertions.sv
tests/id_stage_tb.sv

// ==== Makefile ====
# Verilator flow for the decode stage
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
